/* src.f */
+incdir+.
lsu_pkg.sv
lsu_if.sv
ls_decode.sv
ls_data_mem.sv
ls_load_align.sv
load_store_unit.sv
tb_load_store_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_load_store_unit -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: testbench reported a failure"
    exit 1
fi
echo "run.sh: testbench passed"

/* tb_load_store_unit.sv */
/* Testbench for the load/store unit. The data memory has no reset, so every load
   stays in bytes 0..63, which are written first */
`default_nettype none

`include "lsu_defines.svh"

module tb_load_store_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 10;
    localparam int BYTE_AW         = `LSU_MEM_IDX_W + 2;
    localparam int DIRECTED_OPS    = 41;
    localparam int RANDOM_OPS      = 200;
    localparam int WATCHDOG_CYCLES = (DIRECTED_OPS + RANDOM_OPS) * 20 + 200;

    logic                       clk;
    logic                       rst;
    logic                       in_valid;
    logic                       in_ready;
    lsu_pkg::ls_fn3_e           fn3;
    logic [`LSU_XLEN-1:0]       rs1;
    logic [`LSU_OFFSET_W-1:0]   offset;
    logic [`LSU_XLEN-1:0]       rs2;
    logic                       is_load;
    logic                       is_store;
    logic [`LSU_ID_W-1:0]       id;
    logic                       wb_valid;
    logic                       wb_ready;
    logic [`LSU_XLEN-1:0]       wb_data;
    logic [`LSU_ID_W-1:0]       wb_id;
    logic                       exc_valid;
    lsu_pkg::ls_exc_code_e      exc_code;
    logic [`LSU_XLEN-1:0]       exc_tval;
    logic [`LSU_ID_W-1:0]       exc_id;
    logic                       exc_ack;

    integer                     seed = 32'h8105;
    int                         errors = 0;
    int                         ack_wait;
    logic                       stall_en;
    logic                       stall_seen;
    logic                       exc_checked;
    logic [`LSU_XLEN-1:0]       held_data;
    logic [`LSU_ID_W-1:0]       held_id;
    logic [`LSU_ID_W-1:0]       next_id;

    // Reference byte memory, same wrap as the DUT
    logic [7:0]                 ref_mem [2**BYTE_AW];
    // Pending loads as {id, data}, pending exceptions as {code, tval, id}
    logic [`LSU_ID_W+`LSU_XLEN-1:0]     exp_loads [$];
    logic [4+`LSU_XLEN+`LSU_ID_W-1:0]   exp_excs [$];

    load_store_unit load_store_unit_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    function automatic logic [31:0] eff_addr(logic [31:0] base, logic [11:0] off);
        return base + {{20{off[11]}}, off};
    endfunction

    function automatic logic misaligned(lsu_pkg::ls_fn3_e f, logic [31:0] a);
        case (f[1:0])
            2'b00:   return 1'b0;
            2'b01:   return a[0];
            default: return |a[1:0];
        endcase
    endfunction

    // Little-endian pick from the reference bytes
    function automatic logic [31:0] load_value(lsu_pkg::ls_fn3_e f, logic [31:0] a);
        int         b;
        logic [15:0] half;
        b    = int'(a[BYTE_AW-1:0]);
        half = {ref_mem[b+1], ref_mem[b]};
        case (f)
            lsu_pkg::LB:  return {{24{ref_mem[b][7]}}, ref_mem[b]};
            lsu_pkg::LBU: return {24'h0, ref_mem[b]};
            lsu_pkg::LH:  return {{16{half[15]}}, half};
            lsu_pkg::LHU: return {16'h0, half};
            default:      return {ref_mem[b+3], ref_mem[b+2], half};
        endcase
    endfunction

    function automatic void apply_store(lsu_pkg::ls_fn3_e f, logic [31:0] a, logic [31:0] d);
        int b;
        b = int'(a[BYTE_AW-1:0]);
        ref_mem[b] = d[7:0];
        if (f != lsu_pkg::LB) begin
            ref_mem[b+1] = d[15:8];
        end
        if (f == lsu_pkg::LW) begin
            ref_mem[b+2] = d[23:16];
            ref_mem[b+3] = d[31:24];
        end
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("[ERROR] %0d ns %s: expected 0x%0h, got 0x%0h", $time, sig, exp, act);
    endtask

    ////////////////////////////////////////////////////////////
    // Monitors and checks
    always @(posedge clk) begin : accept_monitor
        logic [31:0] a;
        if (!rst && in_valid && in_ready) begin
            a = eff_addr(rs1, offset);
            if (misaligned(fn3, a)) begin
                exp_excs.push_back({is_store ? lsu_pkg::STORE_ADDR_MISALIGNED
                                             : lsu_pkg::LOAD_ADDR_MISALIGNED, a, id});
            end else if (is_store) begin
                apply_store(fn3, a, rs2);
            end else begin
                exp_loads.push_back({id, load_value(fn3, a)});
            end
        end
    end

    always @(posedge clk) begin : wb_compare
        logic [`LSU_ID_W+`LSU_XLEN-1:0] exp;
        if (!rst && wb_valid && wb_ready) begin
            if (exp_loads.size() == 0) begin
                errors++;
                $display("Writeback of id %0d arrived with no load pending", wb_id);
            end else begin
                exp = exp_loads.pop_front();
                assert (wb_data == exp[31:0]) else report_mismatch("wb_data", exp[31:0], wb_data);
                assert (wb_id == exp[35:32])
                    else report_mismatch("wb_id", 32'(exp[35:32]), 32'(wb_id));
            end
        end
        // Payload held through a stall
        if (!rst && stall_seen) begin
            assert (wb_data == held_data) else report_mismatch("wb_data", held_data, wb_data);
            assert (wb_id == held_id) else report_mismatch("wb_id", 32'(held_id), 32'(wb_id));
        end
        stall_seen = !rst && wb_valid && !wb_ready;
        held_data  = wb_data;
        held_id    = wb_id;
    end

    always @(posedge clk) begin : exc_compare
        logic [4+`LSU_XLEN+`LSU_ID_W-1:0] exp;
        if (rst || !exc_valid) begin
            exc_checked = 1'b0;
        end else if (!exc_checked) begin
            exc_checked = 1'b1;
            if (exp_excs.size() == 0) begin
                errors++;
                $display("Exception with id %0d raised for an aligned access", exc_id);
            end else begin
                exp = exp_excs.pop_front();
                assert (exc_code == exp[39:36])
                    else report_mismatch("exc_code", 32'(exp[39:36]), 32'(exc_code));
                assert (exc_tval == exp[35:4])
                    else report_mismatch("exc_tval", exp[35:4], exc_tval);
                assert (exc_id == exp[3:0])
                    else report_mismatch("exc_id", 32'(exp[3:0]), 32'(exc_id));
            end
        end
    end

    reset_in_ready: assert property (@(posedge clk) $fell(rst) |-> in_ready)
        else report_mismatch("in_ready", 32'd1, 32'd0);
    reset_wb_valid: assert property (@(posedge clk) $fell(rst) |-> !wb_valid)
        else report_mismatch("wb_valid", 32'd0, 32'd1);
    reset_exc_valid: assert property (@(posedge clk) $fell(rst) |-> !exc_valid)
        else report_mismatch("exc_valid", 32'd0, 32'd1);
    wb_held_on_stall: assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_ready |=> wb_valid)
        else report_mismatch("wb_valid", 32'd1, 32'd0);
    exc_held_until_ack: assert property (@(posedge clk) disable iff (rst)
        exc_valid && !exc_ack |=> exc_valid)
        else report_mismatch("exc_valid", 32'd1, 32'd0);
    exc_blocks_input: assert property (@(posedge clk) disable iff (rst)
        exc_valid |-> !in_ready)
        else report_mismatch("in_ready", 32'd0, 32'd1);

    ////////////////////////////////////////////////////////////
    // Environment drivers
    always @(posedge clk) begin
        if (stall_en) begin
            wb_ready <= ($random(seed) % 4) != 0;
        end else begin
            wb_ready <= 1'b1;
        end
    end

    // Ack a few cycles after the exception rises, then drop it
    always @(posedge clk) begin
        if (rst || exc_ack) begin
            exc_ack  <= 1'b0;
            ack_wait <= 0;
        end else if (exc_valid) begin
            if (ack_wait == 3) begin
                exc_ack <= 1'b1;
            end else begin
                ack_wait <= ack_wait + 1;
            end
        end
    end

    task automatic issue(input lsu_pkg::ls_fn3_e f, input logic ld, input logic [31:0] base,
                         input logic [11:0] off, input logic [31:0] data);
        in_valid <= 1'b1;
        fn3      <= f;
        rs1      <= base;
        offset   <= off;
        rs2      <= data;
        is_load  <= ld;
        is_store <= ~ld;
        id       <= next_id;
        do begin
            @(posedge clk);
        end while (!in_ready);
        in_valid <= 1'b0;
        next_id  = next_id + 4'd1;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        int                 lane;
        logic [31:0]        r;
        lsu_pkg::ls_fn3_e   f;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        fn3 = lsu_pkg::LB;
        rs1 = '0;
        offset = '0;
        rs2 = '0;
        is_load = 1'b0;
        is_store = 1'b0;
        id = '0;
        wb_ready = 1'b1;
        exc_ack = 1'b0;
        stall_en = 1'b0;
        stall_seen = 1'b0;
        exc_checked = 1'b0;
        ack_wait = 0;
        next_id = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Fill words 0..15
        for (lane = 0; lane < 16; lane++) begin
            issue(lsu_pkg::LW, 1'b0, 32'(lane * 4), 12'h000, $random(seed));
        end
        // Word round trip, then through a wrapped address
        issue(lsu_pkg::LW, 1'b0, 32'h20, 12'h004, 32'hDEAD_BEEF);
        issue(lsu_pkg::LW, 1'b1, 32'h28, 12'hFFC, 32'h0);
        issue(lsu_pkg::LW, 1'b0, 32'h1000, 12'h010, 32'h0BAD_F00D);
        issue(lsu_pkg::LW, 1'b1, 32'h10, 12'h000, 32'h0);

        // Partial stores, then every load size and lane
        issue(lsu_pkg::LB, 1'b0, 32'h30, 12'h001, 32'h0000_0080);
        issue(lsu_pkg::LH, 1'b0, 32'h34, 12'h002, 32'h0000_F00D);
        issue(lsu_pkg::LW, 1'b1, 32'h30, 12'h000, 32'h0);
        for (lane = 0; lane < 4; lane++) begin
            issue(lsu_pkg::LB, 1'b1, 32'h30, 12'(lane), 32'h0);
            issue(lsu_pkg::LBU, 1'b1, 32'h30, 12'(lane), 32'h0);
        end
        for (lane = 0; lane < 4; lane += 2) begin
            issue(lsu_pkg::LH, 1'b1, 32'h34, 12'(lane), 32'h0);
            issue(lsu_pkg::LHU, 1'b1, 32'h34, 12'(lane), 32'h0);
        end

        // Misaligned loads and stores, then words they must not touch
        issue(lsu_pkg::LH, 1'b1, 32'h10, 12'h001, 32'h0);
        issue(lsu_pkg::LW, 1'b1, 32'h10, 12'h002, 32'h0);
        issue(lsu_pkg::LH, 1'b0, 32'h10, 12'h003, 32'h1234_5678);
        issue(lsu_pkg::LW, 1'b0, 32'h14, 12'h001, 32'hCAFE_F00D);
        issue(lsu_pkg::LW, 1'b1, 32'h10, 12'h000, 32'h0);
        issue(lsu_pkg::LW, 1'b1, 32'h14, 12'h000, 32'h0);

        // Random mix under writeback stalls, addresses 0..62
        stall_en <= 1'b1;
        for (lane = 0; lane < RANDOM_OPS; lane++) begin
            r = $random(seed);
            if (r[0]) begin
                f = (r[3:2] == 2'd0) ? lsu_pkg::LB : (r[3:2] == 2'd1) ? lsu_pkg::LH : lsu_pkg::LW;
            end else begin
                case (r[3:1])
                    3'd0:    f = lsu_pkg::LB;
                    3'd1:    f = lsu_pkg::LH;
                    3'd3:    f = lsu_pkg::LBU;
                    3'd4:    f = lsu_pkg::LHU;
                    default: f = lsu_pkg::LW;
                endcase
            end
            issue(f, ~r[0], {27'd0, r[8:4]} + 32'd16, {{7{r[13]}}, r[13:9]}, $random(seed));
        end
        stall_en <= 1'b0;

        @(posedge clk);
        while (exp_loads.size() != 0 || exp_excs.size() != 0 || exc_valid) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Checks done with %0d error(s)", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* load_store_unit.sv */
/* Load/store unit top. Two-stage pipeline into a local data memory, results in
   order; stores give no writeback */
`default_nettype none

`include "lsu_defines.svh"

module load_store_unit (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // Request side
    input  wire logic                       in_valid,
    output logic                            in_ready,
    input  wire lsu_pkg::ls_fn3_e           fn3,
    input  wire logic [`LSU_XLEN-1:0]       rs1,
    input  wire logic [`LSU_OFFSET_W-1:0]   offset,
    input  wire logic [`LSU_XLEN-1:0]       rs2,
    input  wire logic                       is_load,
    input  wire logic                       is_store,
    input  wire logic [`LSU_ID_W-1:0]       id,

    // Writeback side
    output logic                            wb_valid,
    input  wire logic                       wb_ready,
    output logic [`LSU_XLEN-1:0]            wb_data,
    output logic [`LSU_ID_W-1:0]            wb_id,

    // Exception side
    output logic                            exc_valid,
    output lsu_pkg::ls_exc_code_e           exc_code,
    output logic [`LSU_XLEN-1:0]            exc_tval,
    output logic [`LSU_ID_W-1:0]            exc_id,
    input  wire logic                       exc_ack
);

    mem_req_if  mem_req ();
    load_res_if load_res ();

    ls_decode decode_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .fn3       (fn3),
        .rs1       (rs1),
        .offset    (offset),
        .rs2       (rs2),
        .is_load   (is_load),
        .is_store  (is_store),
        .id        (id),
        .exc_ack   (exc_ack),
        .exc_valid (exc_valid),
        .exc_code  (exc_code),
        .exc_tval  (exc_tval),
        .exc_id    (exc_id),
        .req       (mem_req)
    );

    ls_data_mem data_mem_i (
        .clk (clk),
        .rst (rst),
        .req (mem_req),
        .res (load_res)
    );

    ls_load_align load_align_i (
        .res      (load_res),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_data  (wb_data),
        .wb_id    (wb_id)
    );

endmodule

`default_nettype wire

/* ls_load_align.sv */
/* Load result formatting, fully combinational. Expects aligned accesses only,
   which decode guarantees */
`default_nettype none

`include "lsu_defines.svh"

module ls_load_align (
    load_res_if.sink                res,
    output logic                    wb_valid,
    input  wire logic               wb_ready,
    output logic [`LSU_XLEN-1:0]    wb_data,
    output logic [`LSU_ID_W-1:0]    wb_id
);

    logic [7:0]     byte_sel;
    logic [15:0]    half_sel;
    logic           byte_sign;
    logic           half_sign;

    ////////////////////////////////////////////////////////////
    // Lane select
    assign byte_sel = res.rdata.bytes[res.byte_addr];

    // Bit 0 is zero for an aligned halfword
    assign half_sel = res.rdata.halves[res.byte_addr[1]];

    assign byte_sign = res.is_signed & byte_sel[7];
    assign half_sign = res.is_signed & half_sel[15];

    ////////////////////////////////////////////////////////////
    // Extension
    always_comb begin
        case (res.size)
            lsu_pkg::BYTE: wb_data = {{(`LSU_XLEN-8){byte_sign}}, byte_sel};
            lsu_pkg::HALF: wb_data = {{(`LSU_XLEN-16){half_sign}}, half_sel};
            default:       wb_data = res.rdata.word;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Writeback handshake
    assign wb_valid  = res.valid;
    assign wb_id     = res.id;
    assign res.ready = wb_ready;

endmodule

`default_nettype wire

/* ls_data_mem.sv */
/* Local word-addressed data memory. Address bits above the word index are
   ignored, so accesses wrap; only loads produce a result */
`default_nettype none

`include "lsu_defines.svh"

module ls_data_mem (
    input  wire logic   clk,
    input  wire logic   rst,
    mem_req_if.sink     req,
    load_res_if.source  res
);

    localparam int BE_W = `LSU_XLEN / 8;

    logic [`LSU_XLEN-1:0]       mem [`LSU_MEM_WORDS];
    logic [`LSU_MEM_IDX_W-1:0]  word_idx;
    logic                       xfer;
    logic                       load_xfer;
    logic                       store_xfer;

    ////////////////////////////////////////////////////////////
    // Request acceptance
    assign word_idx   = req.addr[`LSU_MEM_IDX_W+1:2];

    // Stall when the output word is held by the result stage
    assign req.ready  = ~res.valid | res.ready;
    assign xfer       = req.valid & req.ready;
    assign load_xfer  = xfer & req.is_load;
    assign store_xfer = xfer & req.is_store;

    ////////////////////////////////////////////////////////////
    // Memory array
    always_ff @(posedge clk) begin
        for (int i = 0; i < BE_W; i++) begin
            if (store_xfer && req.be[i]) begin
                mem[word_idx][i*8 +: 8] <= req.wdata[i*8 +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else if (req.ready) begin
            res.valid <= load_xfer;
        end
    end

    // Read word and the attributes the result stage needs
    always_ff @(posedge clk) begin
        if (load_xfer) begin
            res.rdata.word <= mem[word_idx];
            res.byte_addr  <= req.addr[1:0];
            res.size       <= req.size;
            res.is_signed  <= req.is_signed;
            res.id         <= req.id;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    res_stable_on_stall: assert property (@(posedge clk) disable iff (rst)
        res.valid && !res.ready |=> res.valid
            && $stable(res.rdata) && $stable(res.byte_addr)
            && $stable(res.size) && $stable(res.is_signed) && $stable(res.id));

endmodule

`default_nettype wire

/* ls_decode.sv */
/* Address generation and alignment check. A misaligned access raises a held
   exception and blocks new requests until exc_ack */
`default_nettype none

`include "lsu_defines.svh"

module ls_decode (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   in_valid,
    output logic                        in_ready,
    input  wire lsu_pkg::ls_fn3_e       fn3,
    input  wire logic [`LSU_XLEN-1:0]   rs1,
    input  wire logic [`LSU_OFFSET_W-1:0] offset,
    input  wire logic [`LSU_XLEN-1:0]   rs2,
    input  wire logic                   is_load,
    input  wire logic                   is_store,
    input  wire logic [`LSU_ID_W-1:0]   id,
    input  wire logic                   exc_ack,
    output logic                        exc_valid,
    output lsu_pkg::ls_exc_code_e       exc_code,
    output logic [`LSU_XLEN-1:0]        exc_tval,
    output logic [`LSU_ID_W-1:0]        exc_id,
    mem_req_if.source                   req
);

    logic [`LSU_XLEN-1:0]   eff_addr;
    lsu_pkg::ls_size_e      size;
    logic                   misaligned;
    logic [`LSU_XLEN/8-1:0] be;
    logic [`LSU_XLEN-1:0]   wdata;
    logic                   accept;
    logic                   new_exc;
    logic                   push;
    logic                   slot_free;

    ////////////////////////////////////////////////////////////
    // Address and access decode
    assign eff_addr = rs1 + {{(`LSU_XLEN-`LSU_OFFSET_W){offset[`LSU_OFFSET_W-1]}}, offset};

    always_comb begin
        case (fn3[1:0])
            2'b00:   size = lsu_pkg::BYTE;
            2'b01:   size = lsu_pkg::HALF;
            default: size = lsu_pkg::WORD;
        endcase
    end

    // Byte lanes and store data replicated into every lane
    always_comb begin
        case (size)
            lsu_pkg::BYTE: begin
                misaligned = 1'b0;
                be         = 4'b0001 << eff_addr[1:0];
                wdata      = {4{rs2[7:0]}};
            end
            lsu_pkg::HALF: begin
                misaligned = eff_addr[0];
                be         = eff_addr[1] ? 4'b1100 : 4'b0011;
                wdata      = {2{rs2[15:0]}};
            end
            default: begin
                misaligned = |eff_addr[1:0];
                be         = 4'b1111;
                wdata      = rs2;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Handshake
    assign slot_free = ~req.valid | req.ready;
    assign in_ready  = slot_free & ~exc_valid;
    assign accept    = in_valid & in_ready & (is_load | is_store);
    assign new_exc   = accept & misaligned;
    assign push      = accept & ~misaligned;

    // Request register
    always_ff @(posedge clk) begin
        if (rst) begin
            req.valid <= 1'b0;
        end else if (slot_free) begin
            req.valid <= push;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            req.addr      <= eff_addr;
            req.be        <= be;
            req.wdata     <= wdata;
            req.is_load   <= is_load;
            req.is_store  <= is_store;
            req.size      <= size;
            req.is_signed <= ~fn3[2];
            req.id        <= id;
        end
    end

    ////////////////////////////////////////////////////////////
    // Held exception
    always_ff @(posedge clk) begin
        if (rst) begin
            exc_valid <= 1'b0;
        end else begin
            exc_valid <= (exc_valid & ~exc_ack) | new_exc;
        end
    end

    always_ff @(posedge clk) begin
        if (new_exc) begin
            exc_code <= is_store ? lsu_pkg::STORE_ADDR_MISALIGNED : lsu_pkg::LOAD_ADDR_MISALIGNED;
            exc_tval <= eff_addr;
            exc_id   <= id;
        end
    end

    // A misaligned item raises the exception and never enters the request register
    misaligned_not_issued: assert property (@(posedge clk) disable iff (rst)
        new_exc |=> exc_valid && !req.valid);

endmodule

`default_nettype wire

/* lsu_if.sv */
/* Internal stage-to-stage links. Both use valid/ready, and the source holds
   valid and payload while ready is low */
`default_nettype none

`include "lsu_defines.svh"

// Decode to execute, one aligned load or store
interface mem_req_if;
    logic                       valid;
    logic                       ready;
    logic [`LSU_XLEN-1:0]       addr;
    logic [`LSU_XLEN/8-1:0]     be;
    logic [`LSU_XLEN-1:0]       wdata;
    logic                       is_load;
    logic                       is_store;
    lsu_pkg::ls_size_e          size;
    logic                       is_signed;
    logic [`LSU_ID_W-1:0]       id;

    modport source (output valid, addr, be, wdata, is_load, is_store, size, is_signed, id,
                    input ready);
    modport sink   (input valid, addr, be, wdata, is_load, is_store, size, is_signed, id,
                    output ready);
endinterface

// Execute to result, raw read word plus load attributes
interface load_res_if;
    logic                       valid;
    logic                       ready;
    lsu_pkg::load_word_u        rdata;
    logic [1:0]                 byte_addr;
    lsu_pkg::ls_size_e          size;
    logic                       is_signed;
    logic [`LSU_ID_W-1:0]       id;

    modport source (output valid, rdata, byte_addr, size, is_signed, id,
                    input ready);
    modport sink   (input valid, rdata, byte_addr, size, is_signed, id,
                    output ready);
endinterface

`default_nettype wire

/* lsu_pkg.sv */
/* Shared types for the load/store unit. Funct3 codes follow the RV32I load
   encodings; stores reuse the low two bits for their size */
`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

    // Funct3 of loads, stores use LB/LH/LW for byte/half/word
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } ls_fn3_e;

    // Exception cause codes, as in mcause
    typedef enum logic [3:0] {
        LOAD_ADDR_MISALIGNED  = 4'd4,
        STORE_ADDR_MISALIGNED = 4'd6
    } ls_exc_code_e;

    // Access size, matches funct3[1:0]
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } ls_size_e;

    // One read word, seen as bytes or as halfwords
    typedef union packed {
        logic [`LSU_XLEN-1:0]             word;
        logic [`LSU_XLEN/8-1:0][7:0]      bytes;
        logic [`LSU_XLEN/16-1:0][15:0]    halves;
    } load_word_u;

endpackage

`default_nettype wire

/* lsu_defines.svh */
/* Sizes for the load/store unit. XLEN is fixed at 32 and the memory index width
   must equal log2 of the memory depth */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data and address word width
`define LSU_XLEN 32

// Data memory depth in words, and its word index width
`define LSU_MEM_WORDS 256
`define LSU_MEM_IDX_W 8

// Signed immediate offset width
`define LSU_OFFSET_W 12

// Instruction id width
`define LSU_ID_W 4

`endif
